/* ooo_settings.svh */
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

// datapath width
`define XLEN 32

// register files
`define NUM_ARCH_REGS 8
`define NUM_PHYS_REGS 32

// window sizes, both powers of two
`define RS_DEPTH 8
`define ROB_DEPTH 16

// issue to CDB, at least 3
`define MUL_LATENCY 3

`endif

/* ooo_pkg.sv */
`default_nettype none

`include "ooo_settings.svh"

package ooo_pkg;

    typedef logic [`XLEN-1:0] data_t;

    // register and ROB indices
    typedef logic [$clog2(`NUM_ARCH_REGS)-1:0] arn_t;
    typedef logic [$clog2(`NUM_PHYS_REGS)-1:0] prn_t;
    typedef logic [$clog2(`ROB_DEPTH)-1:0]     robn_t;

    typedef enum logic [2:0] {
        op_li,
        op_add,
        op_sub,
        op_xor,
        op_mul
    } op_t;

    // last multiply stage, feeding the CDB
    typedef enum logic {
        mul_idle,
        mul_busy
    } mul_state_t;

endpackage

`default_nettype wire

/* rename.sv */
`default_nettype none

`include "ooo_settings.svh"

module rename (
    input  wire                 clock,
    input  wire                 arst_n,
    input  wire                 in_valid,
    output logic                in_ready,
    input  wire ooo_pkg::op_t   in_op,
    input  wire ooo_pkg::arn_t  in_dest,
    input  wire ooo_pkg::arn_t  in_src1,
    input  wire ooo_pkg::arn_t  in_src2,
    input  wire ooo_pkg::data_t in_imm,
    output ooo_pkg::prn_t       src1_prn,
    output ooo_pkg::prn_t       src2_prn,
    input  wire                 src1_ready,
    input  wire                 src2_ready,
    input  wire ooo_pkg::data_t src1_value,
    input  wire ooo_pkg::data_t src2_value,
    input  wire                 rs_full,
    input  wire                 rob_full,
    input  wire ooo_pkg::robn_t rob_tail,
    output logic                disp_valid,
    output ooo_pkg::op_t        disp_op,
    output ooo_pkg::data_t      disp_a,
    output logic                disp_a_ready,
    output ooo_pkg::data_t      disp_b,
    output logic                disp_b_ready,
    output ooo_pkg::prn_t       disp_dest_prn,
    output ooo_pkg::robn_t      disp_robn,
    output ooo_pkg::arn_t       disp_dest_arn,
    output ooo_pkg::prn_t       disp_old_prn,
    output logic                alloc_valid,
    output ooo_pkg::prn_t       alloc_prn,
    input  wire                 free_valid,
    input  wire ooo_pkg::prn_t  free_prn
);
    import ooo_pkg::*;

    prn_t                      map_q [`NUM_ARCH_REGS];
    logic [`NUM_PHYS_REGS-1:0] free_q;

    // lowest free register wins
    always_comb begin
        alloc_prn = '0;
        for (int i = `NUM_PHYS_REGS - 1; i >= 0; i--) begin
            if (free_q[i]) begin
                alloc_prn = prn_t'(i);
            end
        end
    end

    assign in_ready    = (|free_q) && !rs_full && !rob_full;
    assign disp_valid  = in_valid && in_ready;
    assign alloc_valid = disp_valid;

    assign src1_prn = map_q[in_src1];
    assign src2_prn = map_q[in_src2];

    // a waiting operand carries its tag in the low bits
    always_comb begin
        if (in_op == op_li) begin
            disp_a       = in_imm;
            disp_a_ready = 1'b1;
            disp_b       = '0;
            disp_b_ready = 1'b1;
        end else begin
            disp_a       = src1_ready ? src1_value : data_t'(src1_prn);
            disp_a_ready = src1_ready;
            disp_b       = src2_ready ? src2_value : data_t'(src2_prn);
            disp_b_ready = src2_ready;
        end
    end

    assign disp_op       = in_op;
    assign disp_dest_prn = alloc_prn;
    assign disp_robn     = rob_tail;
    assign disp_dest_arn = in_dest;
    assign disp_old_prn  = map_q[in_dest];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < `NUM_ARCH_REGS; r++) begin
                map_q[r] <= prn_t'(r);
            end
            for (int p = 0; p < `NUM_PHYS_REGS; p++) begin
                free_q[p] <= (p >= `NUM_ARCH_REGS);
            end
        end else begin
            if (disp_valid) begin
                map_q[in_dest]    <= alloc_prn;
                free_q[alloc_prn] <= 1'b0;
            end
            // old mapping handed back by commit
            if (free_valid) begin
                free_q[free_prn] <= 1'b1;
            end
        end
    end

    a_no_double_free: assert property (@(posedge clock) disable iff (!arst_n)
        free_valid |-> !free_q[free_prn]);

endmodule

`default_nettype wire

/* prf.sv */
`default_nettype none

`include "ooo_settings.svh"

module prf (
    input  wire                 clock,
    input  wire                 arst_n,
    input  wire ooo_pkg::prn_t  src1_prn,
    input  wire ooo_pkg::prn_t  src2_prn,
    output logic                src1_ready,
    output ooo_pkg::data_t      src1_value,
    output logic                src2_ready,
    output ooo_pkg::data_t      src2_value,
    input  wire                 alloc_valid,
    input  wire ooo_pkg::prn_t  alloc_prn,
    input  wire                 cdb_valid,
    input  wire ooo_pkg::prn_t  cdb_prn,
    input  wire ooo_pkg::data_t cdb_value,
    input  wire ooo_pkg::prn_t  head_prn,
    output ooo_pkg::data_t      head_value
);
    import ooo_pkg::*;

    data_t                     value_q [`NUM_PHYS_REGS];
    logic [`NUM_PHYS_REGS-1:0] ready_q;
    logic                      hit1, hit2;

    // forward this cycle's broadcast to rename
    assign hit1 = cdb_valid && (cdb_prn == src1_prn);
    assign hit2 = cdb_valid && (cdb_prn == src2_prn);

    assign src1_ready = ready_q[src1_prn] || hit1;
    assign src1_value = hit1 ? cdb_value : value_q[src1_prn];
    assign src2_ready = ready_q[src2_prn] || hit2;
    assign src2_value = hit2 ? cdb_value : value_q[src2_prn];

    // head result was written at least one edge ago
    assign head_value = value_q[head_prn];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ready_q <= '1;
            for (int p = 0; p < `NUM_PHYS_REGS; p++) begin
                value_q[p] <= '0;
            end
        end else begin
            if (alloc_valid) begin
                ready_q[alloc_prn] <= 1'b0;
            end
            if (cdb_valid) begin
                ready_q[cdb_prn] <= 1'b1;
                value_q[cdb_prn] <= cdb_value;
            end
        end
    end

    a_cdb_to_pending: assert property (@(posedge clock) disable iff (!arst_n)
        cdb_valid |-> !ready_q[cdb_prn]);

endmodule

`default_nettype wire

/* rs.sv */
`default_nettype none

`include "ooo_settings.svh"

module rs (
    input  wire                 clock,
    input  wire                 arst_n,
    input  wire                 disp_valid,
    input  wire ooo_pkg::op_t   disp_op,
    input  wire ooo_pkg::data_t disp_a,
    input  wire                 disp_a_ready,
    input  wire ooo_pkg::data_t disp_b,
    input  wire                 disp_b_ready,
    input  wire ooo_pkg::prn_t  disp_dest_prn,
    input  wire ooo_pkg::robn_t disp_robn,
    output logic                rs_full,
    input  wire                 cdb_valid,
    input  wire ooo_pkg::prn_t  cdb_prn,
    input  wire ooo_pkg::data_t cdb_value,
    input  wire                 alu_avail,
    output logic                alu_issue,
    output ooo_pkg::op_t        alu_op,
    output ooo_pkg::data_t      alu_a,
    output ooo_pkg::data_t      alu_b,
    output ooo_pkg::prn_t       alu_prn,
    output ooo_pkg::robn_t      alu_robn,
    output logic                mul_issue,
    output ooo_pkg::data_t      mul_a,
    output ooo_pkg::data_t      mul_b,
    output ooo_pkg::prn_t       mul_prn,
    output ooo_pkg::robn_t      mul_robn
);
    import ooo_pkg::*;

    localparam int IdxW = $clog2(`RS_DEPTH);

    logic [`RS_DEPTH-1:0] valid_q, a_rdy_q, b_rdy_q;
    logic [`RS_DEPTH-1:0] wake_a, wake_b, ready;
    op_t                  op_q   [`RS_DEPTH];
    data_t                a_q    [`RS_DEPTH];
    data_t                b_q    [`RS_DEPTH];
    prn_t                 dest_q [`RS_DEPTH];
    robn_t                robn_q [`RS_DEPTH];
    logic [IdxW-1:0]      alu_sel, mul_sel, free_sel;

    always_comb begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            wake_a[i] = cdb_valid && valid_q[i] && !a_rdy_q[i] && (prn_t'(a_q[i]) == cdb_prn);
            wake_b[i] = cdb_valid && valid_q[i] && !b_rdy_q[i] && (prn_t'(b_q[i]) == cdb_prn);
            ready[i]  = valid_q[i] && a_rdy_q[i] && b_rdy_q[i];
        end
    end

    assign rs_full = &valid_q;

    // descending scan leaves the lowest index
    always_comb begin
        alu_issue = 1'b0;
        mul_issue = 1'b0;
        alu_sel   = '0;
        mul_sel   = '0;
        free_sel  = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (ready[i] && op_q[i] != op_mul) begin
                alu_issue = alu_avail;
                alu_sel   = IdxW'(i);
            end
            if (ready[i] && op_q[i] == op_mul) begin
                mul_issue = 1'b1;
                mul_sel   = IdxW'(i);
            end
            if (!valid_q[i]) begin
                free_sel = IdxW'(i);
            end
        end
    end

    assign alu_op   = op_q[alu_sel];
    assign alu_a    = a_q[alu_sel];
    assign alu_b    = b_q[alu_sel];
    assign alu_prn  = dest_q[alu_sel];
    assign alu_robn = robn_q[alu_sel];
    assign mul_a    = a_q[mul_sel];
    assign mul_b    = b_q[mul_sel];
    assign mul_prn  = dest_q[mul_sel];
    assign mul_robn = robn_q[mul_sel];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
            a_rdy_q <= '0;
            b_rdy_q <= '0;
        end else begin
            a_rdy_q <= a_rdy_q | wake_a;
            b_rdy_q <= b_rdy_q | wake_b;
            if (alu_issue) begin
                valid_q[alu_sel] <= 1'b0;
            end
            if (mul_issue) begin
                valid_q[mul_sel] <= 1'b0;
            end
            if (disp_valid) begin
                valid_q[free_sel] <= 1'b1;
                a_rdy_q[free_sel] <= disp_a_ready;
                b_rdy_q[free_sel] <= disp_b_ready;
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (wake_a[i]) begin
                a_q[i] <= cdb_value;
            end
            if (wake_b[i]) begin
                b_q[i] <= cdb_value;
            end
        end
        if (disp_valid) begin
            op_q[free_sel]   <= disp_op;
            a_q[free_sel]    <= disp_a;
            b_q[free_sel]    <= disp_b;
            dest_q[free_sel] <= disp_dest_prn;
            robn_q[free_sel] <= disp_robn;
        end
    end

    a_issue_ready: assert property (@(posedge clock) disable iff (!arst_n)
        (alu_issue -> ready[alu_sel]) && (mul_issue -> ready[mul_sel]));

endmodule

`default_nettype wire

/* fu_cdb.sv */
`default_nettype none

`include "ooo_settings.svh"

module fu_cdb (
    input  wire                 clock,
    input  wire                 arst_n,
    input  wire                 alu_issue,
    input  wire ooo_pkg::op_t   alu_op,
    input  wire ooo_pkg::data_t alu_a,
    input  wire ooo_pkg::data_t alu_b,
    input  wire ooo_pkg::prn_t  alu_prn,
    input  wire ooo_pkg::robn_t alu_robn,
    input  wire                 mul_issue,
    input  wire ooo_pkg::data_t mul_a,
    input  wire ooo_pkg::data_t mul_b,
    input  wire ooo_pkg::prn_t  mul_prn,
    input  wire ooo_pkg::robn_t mul_robn,
    output logic                alu_avail,
    output logic                cdb_valid,
    output ooo_pkg::prn_t       cdb_prn,
    output ooo_pkg::robn_t      cdb_robn,
    output ooo_pkg::data_t      cdb_value
);
    import ooo_pkg::*;

    // multiply stages registered ahead of the CDB register
    localparam int Stages = `MUL_LATENCY - 1;

    data_t             alu_result;
    logic [Stages-2:0] mv_q;
    mul_state_t        slot_q;
    data_t             mp_q    [Stages];
    prn_t              mprn_q  [Stages];
    robn_t             mrobn_q [Stages];

    always_comb begin
        case (alu_op)
            op_add:  alu_result = alu_a + alu_b;
            op_sub:  alu_result = alu_a - alu_b;
            op_xor:  alu_result = alu_a ^ alu_b;
            default: alu_result = alu_a;
        endcase
    end

    // an occupied last stage takes the CDB at the next edge
    assign alu_avail = (slot_q == mul_idle);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            mv_q      <= '0;
            slot_q    <= mul_idle;
            cdb_valid <= 1'b0;
        end else begin
            mv_q[0] <= mul_issue;
            for (int k = 1; k < Stages - 1; k++) begin
                mv_q[k] <= mv_q[k-1];
            end
            slot_q    <= mv_q[Stages-2] ? mul_busy : mul_idle;
            cdb_valid <= (slot_q == mul_busy) || alu_issue;
        end
    end

    // product kept to XLEN low bits
    always_ff @(posedge clock) begin
        mp_q[0]    <= mul_a * mul_b;
        mprn_q[0]  <= mul_prn;
        mrobn_q[0] <= mul_robn;
        for (int k = 1; k < Stages; k++) begin
            mp_q[k]    <= mp_q[k-1];
            mprn_q[k]  <= mprn_q[k-1];
            mrobn_q[k] <= mrobn_q[k-1];
        end
        if (slot_q == mul_busy) begin
            cdb_prn   <= mprn_q[Stages-1];
            cdb_robn  <= mrobn_q[Stages-1];
            cdb_value <= mp_q[Stages-1];
        end else begin
            cdb_prn   <= alu_prn;
            cdb_robn  <= alu_robn;
            cdb_value <= alu_result;
        end
    end

endmodule

`default_nettype wire

/* rob.sv */
`default_nettype none

`include "ooo_settings.svh"

module rob (
    input  wire                 clock,
    input  wire                 arst_n,
    input  wire                 disp_valid,
    input  wire ooo_pkg::arn_t  disp_dest_arn,
    input  wire ooo_pkg::prn_t  disp_dest_prn,
    input  wire ooo_pkg::prn_t  disp_old_prn,
    output ooo_pkg::robn_t      rob_tail,
    output logic                rob_full,
    input  wire                 cdb_valid,
    input  wire ooo_pkg::robn_t cdb_robn,
    output ooo_pkg::prn_t       head_prn,
    input  wire ooo_pkg::data_t head_value,
    output logic                ct_valid,
    input  wire                 ct_ready,
    output ooo_pkg::arn_t       ct_dest,
    output ooo_pkg::data_t      ct_value,
    output logic                free_valid,
    output ooo_pkg::prn_t       free_prn
);
    import ooo_pkg::*;

    robn_t                       head_q, tail_q;
    logic [$clog2(`ROB_DEPTH):0] count_q;
    logic [`ROB_DEPTH-1:0]       done_q;
    arn_t                        arn_q [`ROB_DEPTH];
    prn_t                        prn_q [`ROB_DEPTH];
    prn_t                        old_q [`ROB_DEPTH];
    logic                        commit;

    assign rob_tail = tail_q;
    assign rob_full = (count_q == `ROB_DEPTH);

    // head holds still until the consumer takes it
    assign ct_valid   = (count_q != 0) && done_q[head_q];
    assign commit     = ct_valid && ct_ready;
    assign head_prn   = prn_q[head_q];
    assign ct_dest    = arn_q[head_q];
    assign ct_value   = head_value;
    assign free_valid = commit;
    assign free_prn   = old_q[head_q];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            done_q  <= '0;
        end else begin
            if (disp_valid) begin
                tail_q         <= tail_q + 1'b1;
                done_q[tail_q] <= 1'b0;
            end
            if (cdb_valid) begin
                done_q[cdb_robn] <= 1'b1;
            end
            if (commit) begin
                head_q <= head_q + 1'b1;
            end
            case ({disp_valid, commit})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (disp_valid) begin
            arn_q[tail_q] <= disp_dest_arn;
            prn_q[tail_q] <= disp_dest_prn;
            old_q[tail_q] <= disp_old_prn;
        end
    end

    // pointers meet only when the buffer is empty or full
    a_commit_nonempty: assert property (@(posedge clock) disable iff (!arst_n)
        commit |-> (head_q != tail_q) || rob_full);

    // each instruction is broadcast once
    a_single_complete: assert property (@(posedge clock) disable iff (!arst_n)
        cdb_valid |-> !done_q[cdb_robn]);

endmodule

`default_nettype wire

/* ooo.sv */
`default_nettype none

module ooo (
    input  wire                 clock,
    input  wire                 arst_n,
    input  wire                 in_valid,
    output logic                in_ready,
    input  wire ooo_pkg::op_t   in_op,
    input  wire ooo_pkg::arn_t  in_dest,
    input  wire ooo_pkg::arn_t  in_src1,
    input  wire ooo_pkg::arn_t  in_src2,
    input  wire ooo_pkg::data_t in_imm,
    output logic                ct_valid,
    input  wire                 ct_ready,
    output ooo_pkg::arn_t       ct_dest,
    output ooo_pkg::data_t      ct_value
);
    import ooo_pkg::*;

    // rename to prf
    prn_t  src1_prn, src2_prn, alloc_prn;
    logic  src1_ready, src2_ready, alloc_valid;
    data_t src1_value, src2_value;

    // dispatch
    logic  disp_valid, disp_a_ready, disp_b_ready;
    op_t   disp_op;
    data_t disp_a, disp_b;
    prn_t  disp_dest_prn, disp_old_prn;
    robn_t disp_robn, rob_tail;
    arn_t  disp_dest_arn;
    logic  rs_full, rob_full;

    // issue
    logic  alu_issue, mul_issue, alu_avail;
    op_t   alu_op;
    data_t alu_a, alu_b, mul_a, mul_b;
    prn_t  alu_prn, mul_prn;
    robn_t alu_robn, mul_robn;

    // CDB and commit
    logic  cdb_valid, free_valid;
    prn_t  cdb_prn, head_prn, free_prn;
    robn_t cdb_robn;
    data_t cdb_value, head_value;

    rename rename_i (
        .clock, .arst_n, .in_valid, .in_ready, .in_op, .in_dest, .in_src1, .in_src2, .in_imm,
        .src1_prn, .src2_prn, .src1_ready, .src2_ready, .src1_value, .src2_value,
        .rs_full, .rob_full, .rob_tail,
        .disp_valid, .disp_op, .disp_a, .disp_a_ready, .disp_b, .disp_b_ready,
        .disp_dest_prn, .disp_robn, .disp_dest_arn, .disp_old_prn,
        .alloc_valid, .alloc_prn, .free_valid, .free_prn
    );

    prf prf_i (
        .clock, .arst_n,
        .src1_prn, .src2_prn, .src1_ready, .src1_value, .src2_ready, .src2_value,
        .alloc_valid, .alloc_prn, .cdb_valid, .cdb_prn, .cdb_value, .head_prn, .head_value
    );

    rs rs_i (
        .clock, .arst_n,
        .disp_valid, .disp_op, .disp_a, .disp_a_ready, .disp_b, .disp_b_ready,
        .disp_dest_prn, .disp_robn, .rs_full, .cdb_valid, .cdb_prn, .cdb_value, .alu_avail,
        .alu_issue, .alu_op, .alu_a, .alu_b, .alu_prn, .alu_robn,
        .mul_issue, .mul_a, .mul_b, .mul_prn, .mul_robn
    );

    fu_cdb fu_cdb_i (
        .clock, .arst_n,
        .alu_issue, .alu_op, .alu_a, .alu_b, .alu_prn, .alu_robn,
        .mul_issue, .mul_a, .mul_b, .mul_prn, .mul_robn,
        .alu_avail, .cdb_valid, .cdb_prn, .cdb_robn, .cdb_value
    );

    rob rob_i (
        .clock, .arst_n, .disp_valid, .disp_dest_arn, .disp_dest_prn, .disp_old_prn,
        .rob_tail, .rob_full, .cdb_valid, .cdb_robn, .head_prn, .head_value,
        .ct_valid, .ct_ready, .ct_dest, .ct_value, .free_valid, .free_prn
    );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
    parameter int Period = 8
) (
    output logic clock
);

    initial begin
        clock = 1'b0;
        forever begin
            #(Period / 2);
            clock = ~clock;
        end
    end

endmodule

`default_nettype wire

/* ooo_tb.sv */
`default_nettype none

`include "ooo_settings.svh"

module ooo_tb;
    import ooo_pkg::*;

    localparam int NumRows     = 64;
    localparam int StallRow    = 24;
    localparam int StallCycles = 40;
    // per-row worst case, doubled, plus room for the stall window
    localparam int WorstCycles = `MUL_LATENCY + `ROB_DEPTH + 4;
    localparam int TimeoutCycles = NumRows * WorstCycles * 2 + StallCycles + 100;

    logic  clock;
    logic  arst_n;
    logic  in_valid;
    logic  in_ready;
    op_t   in_op;
    arn_t  in_dest;
    arn_t  in_src1;
    arn_t  in_src2;
    data_t in_imm;
    logic  ct_valid;
    logic  ct_ready;
    arn_t  ct_dest;
    data_t ct_value;

    // stimulus and expected result per row
    op_t   row_op   [NumRows];
    arn_t  row_dest [NumRows];
    arn_t  row_src1 [NumRows];
    arn_t  row_src2 [NumRows];
    data_t row_imm  [NumRows];
    data_t row_exp  [NumRows];
    string row_name [NumRows];
    int    n_rows;

    // architectural state of the reference model
    data_t model_regs [`NUM_ARCH_REGS];

    int pending_q [$];
    int committed;
    int stall_left;
    bit saw_stall;
    int seed;

    tb_clock_gen #(.Period(8)) clock_i (.clock(clock));

    ooo dut_i (
        .clock    (clock),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_op    (in_op),
        .in_dest  (in_dest),
        .in_src1  (in_src1),
        .in_src2  (in_src2),
        .in_imm   (in_imm),
        .ct_valid (ct_valid),
        .ct_ready (ct_ready),
        .ct_dest  (ct_dest),
        .ct_value (ct_value)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input data_t expected, input data_t actual);
        if (expected !== actual) begin
            abort_run($sformatf("error: test %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // results wrap to XLEN bits, multiply keeps the low half
    function automatic data_t ref_result(op_t op, data_t a, data_t b, data_t imm);
        data_t r;
        case (op)
            op_li:   r = imm;
            op_add:  r = a + b;
            op_sub:  r = a - b;
            op_xor:  r = a ^ b;
            default: r = a * b;
        endcase
        return r;
    endfunction

    task automatic add_row(input op_t op, input arn_t dest, input arn_t src1,
                           input arn_t src2, input data_t imm, input string name);
        row_op[n_rows]   = op;
        row_dest[n_rows] = dest;
        row_src1[n_rows] = src1;
        row_src2[n_rows] = src2;
        row_imm[n_rows]  = imm;
        row_name[n_rows] = name;
        row_exp[n_rows]  = ref_result(op, model_regs[src1], model_regs[src2], imm);
        model_regs[dest] = row_exp[n_rows];
        n_rows++;
    endtask

    task automatic build_table();
        n_rows = 0;
        for (int r = 0; r < `NUM_ARCH_REGS; r++) begin
            model_regs[r] = '0;
        end
        // every register read once straight after reset
        add_row(op_add, 0, 0, 1, 0, "reset_r0_r1");
        add_row(op_add, 2, 2, 3, 0, "reset_r2_r3");
        add_row(op_add, 4, 4, 5, 0, "reset_r4_r5");
        add_row(op_add, 6, 6, 7, 0, "reset_r6_r7");
        // one of each operation
        add_row(op_li,  1, 0, 0, 32'h1234_5678, "li_r1");
        add_row(op_li,  2, 0, 0, 32'h0000_0003, "li_r2");
        add_row(op_add, 3, 1, 2, 0, "add");
        add_row(op_sub, 4, 2, 1, 0, "sub_wrap");
        add_row(op_xor, 5, 1, 4, 0, "xor");
        add_row(op_li,  6, 0, 0, 32'hffff_fff0, "li_r6");
        add_row(op_mul, 7, 6, 1, 0, "mul_low_bits");
        // dependences through in-flight multiplies
        add_row(op_mul, 0, 1, 2, 0, "raw_mul");
        add_row(op_add, 0, 0, 0, 0, "raw_after_mul");
        add_row(op_mul, 0, 0, 2, 0, "mul_chain");
        add_row(op_sub, 3, 0, 3, 0, "raw_mul_chain");
        add_row(op_li,  3, 0, 0, 32'h0000_0007, "waw_li");
        add_row(op_add, 3, 3, 3, 0, "waw_add");
        // ALU ops overtake the multiply on the CDB
        add_row(op_mul, 5, 6, 6, 0, "mul_first");
        add_row(op_add, 1, 2, 2, 0, "alu_after_mul_a");
        add_row(op_xor, 2, 2, 4, 0, "alu_after_mul_b");
        add_row(op_li,  4, 0, 0, 32'ha5a5_a5a5, "alu_after_mul_c");
        add_row(op_add, 6, 5, 1, 0, "use_mul_result");
        // random tail, long enough to recycle physical registers
        while (n_rows < NumRows) begin
            add_row(op_t'({$random(seed)} % 5),
                    arn_t'({$random(seed)} % `NUM_ARCH_REGS),
                    arn_t'({$random(seed)} % `NUM_ARCH_REGS),
                    arn_t'({$random(seed)} % `NUM_ARCH_REGS),
                    data_t'($random(seed)),
                    $sformatf("rand_%0d", n_rows));
        end
    endtask

    initial begin
        seed       = 90;
        arst_n     = 1'b0;
        in_valid   = 1'b0;
        in_op      = op_li;
        in_dest    = '0;
        in_src1    = '0;
        in_src2    = '0;
        in_imm     = '0;
        ct_ready   = 1'b0;
        committed  = 0;
        stall_left = 0;
        saw_stall  = 1'b0;
        build_table();

        repeat (4) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
        @(negedge clock);
        check_value("after_reset_ct_valid", 0, data_t'(ct_valid));
        check_value("after_reset_in_ready", 1, data_t'(in_ready));

        for (int i = 0; i < NumRows; i++) begin
            in_valid = 1'b1;
            in_op    = row_op[i];
            in_dest  = row_dest[i];
            in_src1  = row_src1[i];
            in_src2  = row_src2[i];
            in_imm   = row_imm[i];
            if (i == StallRow) begin
                stall_left = StallCycles;
            end
            // in_ready only moves on rising edges
            while (!in_ready) begin
                saw_stall = 1'b1;
                @(negedge clock);
            end
            pending_q.push_back(i);
            @(negedge clock);
        end
        in_valid = 1'b0;

        while (committed < NumRows) begin
            @(negedge clock);
        end
        // a stray commit here would hit an empty queue
        repeat (10) @(negedge clock);

        if (!saw_stall) begin
            abort_run("in_ready never dropped while commits were held back");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

    // commit side, ct_ready set for the coming edge
    initial begin
        int idx;
        forever begin
            @(negedge clock);
            if (stall_left > 0) begin
                ct_ready = 1'b0;
                stall_left--;
            end else begin
                ct_ready = ({$random(seed)} % 4) != 0;
            end
            if (arst_n && ct_valid && ct_ready) begin
                if (pending_q.size() == 0) begin
                    abort_run("a commit happened with no instruction outstanding");
                end else begin
                    idx = pending_q.pop_front();
                    check_value({row_name[idx], "_dest"}, data_t'(row_dest[idx]),
                                data_t'(ct_dest));
                    check_value(row_name[idx], row_exp[idx], ct_value);
                    committed++;
                end
            end
        end
    end

    initial begin
        repeat (TimeoutCycles) @(posedge clock);
        abort_run($sformatf("timeout after %0d cycles with %0d of %0d rows committed",
                            TimeoutCycles, committed, NumRows));
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
ooo_pkg.sv
rename.sv
prf.sv
rs.sv
fu_cdb.sv
rob.sv
ooo.sv
tb_clock_gen.sv
ooo_tb.sv

/* run.sh */
#!/bin/sh
# builds and runs ooo_tb with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module ooo_tb -o ooo_sim \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/ooo_sim > sim.log 2>&1

grep -q "TB FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
